//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = pcs_rx_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, search the log for the pass message"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+verification
source/pcs_pkg.sv
source/gearbox_rx.sv
source/block_sync_rx.sv
source/descrambler_rx.sv
source/dec_lite_rx.sv
source/pcs_rx.sv
verification/pcs_rx_tb.sv

//--- source/block_sync_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// sync header lock, one slip per bad header while hunting
// 4 blocks ignored after each slip for the gearbox to settle
// once locked only SH_BAD_MAX bad headers in a window drop lock
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_sync_rx #(
	parameter int SH_CNT_N = 64,
	parameter int SH_BAD_MAX = 16
)(
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        valid_i,
	input  logic [pcs_pkg::HEAD_W-1:0]  head_i,
	output logic                        slip_o,
	output logic                        lock_o
);
	localparam int SH_CNT_W = $clog2(SH_CNT_N + 1);
	localparam int BAD_CNT_W = $clog2(SH_BAD_MAX + 1);

	pcs_pkg::sync_state_e state_q;
	logic [SH_CNT_W-1:0]  sh_cnt_q;
	logic [BAD_CNT_W-1:0] bad_cnt_q;
	logic [1:0]           settle_q;
	logic                 sh_ok;
	logic                 win_end;
	logic                 bad_max;

	// only 01 and 10 are legal headers
	assign sh_ok = (head_i == pcs_pkg::SH_DATA) || (head_i == pcs_pkg::SH_CTRL);
	// last header of the test window
	assign win_end = sh_cnt_q == SH_CNT_W'(SH_CNT_N - 1);
	// one more bad header loses lock
	assign bad_max = bad_cnt_q == BAD_CNT_W'(SH_BAD_MAX - 1);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= pcs_pkg::LOCK_INIT;
			sh_cnt_q <= '0;
			bad_cnt_q <= '0;
			settle_q <= '0;
			slip_o <= 1'b0;
		end else begin
			// slip is a single cycle pulse
			slip_o <= 1'b0;
			case (state_q)
				pcs_pkg::LOCK_INIT: begin
					sh_cnt_q <= '0;
					bad_cnt_q <= '0;
					state_q <= pcs_pkg::TEST_SH;
				end
				pcs_pkg::TEST_SH: begin
					if (valid_i) begin
						if (!sh_ok) begin
							// hunting, any bad header shifts by one bit
							slip_o <= 1'b1;
							settle_q <= '0;
							state_q <= pcs_pkg::SLIP;
						end else if (win_end) begin
							sh_cnt_q <= '0;
							bad_cnt_q <= '0;
							state_q <= pcs_pkg::LOCKED;
						end else begin
							sh_cnt_q <= sh_cnt_q + 1'b1;
						end
					end
				end
				pcs_pkg::SLIP: begin
					// skip blocks still formed at the old alignment
					if (valid_i) begin
						settle_q <= settle_q + 1'b1;
						if (settle_q == 2'd3) begin
							state_q <= pcs_pkg::LOCK_INIT;
						end
					end
				end
				pcs_pkg::LOCKED: begin
					if (valid_i) begin
						if (!sh_ok && bad_max) begin
							slip_o <= 1'b1;
							settle_q <= '0;
							state_q <= pcs_pkg::SLIP;
						end else if (win_end) begin
							// new window
							sh_cnt_q <= '0;
							bad_cnt_q <= '0;
						end else begin
							sh_cnt_q <= sh_cnt_q + 1'b1;
							bad_cnt_q <= bad_cnt_q + BAD_CNT_W'(!sh_ok);
						end
					end
				end
				default: state_q <= pcs_pkg::LOCK_INIT;
			endcase
		end
	end

	assign lock_o = state_q == pcs_pkg::LOCKED;

endmodule

//--- source/dec_lite_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// lite mac decode of one 66 bit block, one cycle latency
// control payload is shifted down past the type byte
// flags and valid stay low while block lock is down
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dec_lite_rx (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        valid_i,
	input  logic                        lock_i,
	input  logic [pcs_pkg::HEAD_W-1:0]  head_i,
	input  logic [pcs_pkg::DATA_W-1:0]  data_i,
	output logic                        valid_o,
	output logic                        ctrl_v_o,
	output logic                        idle_v_o,
	output logic                        start_v_o,
	output logic                        term_v_o,
	output logic                        err_v_o,
	output logic                        ord_v_o,
	output logic [pcs_pkg::DATA_W-1:0]  data_o,
	output logic [pcs_pkg::KEEP_W-1:0]  keep_o
);
	pcs_pkg::block_type_e        btype;
	logic                        blk_v;
	logic                        ctrl;
	logic                        idle;
	logic                        start;
	logic                        term;
	logic                        err;
	logic                        ord;
	logic [pcs_pkg::DATA_W-1:0]  data;
	logic [pcs_pkg::KEEP_W-1:0]  keep;

	assign blk_v = valid_i & lock_i;
	assign btype = pcs_pkg::block_type_e'(data_i[7:0]);

	always_comb begin
		ctrl = 1'b0;
		idle = 1'b0;
		start = 1'b0;
		term = 1'b0;
		err = 1'b0;
		ord = 1'b0;
		data = data_i;
		keep = '0;
		if (head_i == pcs_pkg::SH_DATA) begin
			keep = '1;
		end else if (head_i == pcs_pkg::SH_CTRL) begin
			ctrl = 1'b1;
			// drop the type byte
			data = {8'h00, data_i[pcs_pkg::DATA_W-1:8]};
			case (btype)
				pcs_pkg::BT_IDLE:  idle = 1'b1;
				pcs_pkg::BT_ORD:   ord = 1'b1;
				pcs_pkg::BT_START: begin
					start = 1'b1;
					keep = 8'h7f;
				end
				// term k keeps k data bytes
				pcs_pkg::BT_TERM0: term = 1'b1;
				pcs_pkg::BT_TERM1: {term, keep} = {1'b1, 8'h01};
				pcs_pkg::BT_TERM2: {term, keep} = {1'b1, 8'h03};
				pcs_pkg::BT_TERM3: {term, keep} = {1'b1, 8'h07};
				pcs_pkg::BT_TERM4: {term, keep} = {1'b1, 8'h0f};
				pcs_pkg::BT_TERM5: {term, keep} = {1'b1, 8'h1f};
				pcs_pkg::BT_TERM6: {term, keep} = {1'b1, 8'h3f};
				pcs_pkg::BT_TERM7: {term, keep} = {1'b1, 8'h7f};
				// unknown block type
				default: err = 1'b1;
			endcase
		end else begin
			// 00 or 11 header
			err = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			ctrl_v_o <= 1'b0;
			idle_v_o <= 1'b0;
			start_v_o <= 1'b0;
			term_v_o <= 1'b0;
			err_v_o <= 1'b0;
			ord_v_o <= 1'b0;
		end else begin
			valid_o <= blk_v;
			ctrl_v_o <= blk_v & ctrl;
			idle_v_o <= blk_v & idle;
			start_v_o <= blk_v & start;
			term_v_o <= blk_v & term;
			err_v_o <= blk_v & err;
			ord_v_o <= blk_v & ord;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			data_o <= data;
			keep_o <= keep;
		end
	end

endmodule

//--- source/descrambler_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// self-synchronising descrambler, 1 + x^39 + x^58
// header is not scrambled and travels alongside
// first block after start up decodes garbage until history fills
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module descrambler_rx (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        valid_i,
	input  logic [pcs_pkg::HEAD_W-1:0]  head_i,
	input  logic [pcs_pkg::DATA_W-1:0]  scram_i,
	output logic                        valid_o,
	output logic [pcs_pkg::HEAD_W-1:0]  head_o,
	output logic [pcs_pkg::DATA_W-1:0]  data_o
);
	localparam int TAP_A = 39;
	localparam int TAP_B = 58;

	// history msb is the most recent received bit
	logic [TAP_B-1:0]                 hist_q;
	logic [TAP_B+pcs_pkg::DATA_W-1:0] ext;
	logic [pcs_pkg::DATA_W-1:0]       plain;

	// received stream, oldest bit at index 0
	assign ext = {scram_i, hist_q};

	always_comb begin
		for (int i = 0; i < pcs_pkg::DATA_W; i++) begin
			plain[i] = ext[TAP_B+i] ^ ext[TAP_B+i-TAP_A] ^ ext[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// history only moves on real blocks
	always_ff @(posedge clk) begin
		if (valid_i) begin
			hist_q <= ext[TAP_B+pcs_pkg::DATA_W-1 -: TAP_B];
			head_o <= head_i;
			data_o <= plain;
		end
	end

endmodule

//--- source/gearbox_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// 64 bit serdes words in, 66 bit blocks out, no back-pressure
// roughly one cycle in 33 carries no block
// a slip drops exactly one bit, buffer clears while serdes lock is low
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gearbox_rx (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        lock_v_i,
	input  logic [pcs_pkg::DATA_W-1:0]  data_i,
	input  logic                        slip_i,
	output logic                        valid_o,
	output logic [pcs_pkg::HEAD_W-1:0]  head_o,
	output logic [pcs_pkg::DATA_W-1:0]  data_o
);
	// held bits stay below 66 between cycles, so 65 + 64 fits
	localparam int BUF_W = pcs_pkg::BLOCK_W + pcs_pkg::DATA_W;
	localparam int CNT_W = $clog2(BUF_W + 1);

	logic [BUF_W-1:0] shift_q;
	logic [BUF_W-1:0] shift_fill;
	logic [BUF_W-1:0] shift_slip;
	logic [BUF_W-1:0] shift_next;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_fill;
	logic [CNT_W-1:0] cnt_slip;
	logic [CNT_W-1:0] cnt_next;
	logic             emit;

	always_comb begin
		// append new word just above the held bits
		shift_fill = shift_q | ({{(BUF_W-pcs_pkg::DATA_W){1'b0}}, data_i} << cnt_q);
		cnt_fill = cnt_q + CNT_W'(pcs_pkg::DATA_W);
		// slip drops the oldest bit, always at least 64 held here
		shift_slip = shift_fill;
		cnt_slip = cnt_fill;
		if (slip_i) begin
			shift_slip = shift_fill >> 1;
			cnt_slip = cnt_fill - 1'b1;
		end
		// emit lowest 66 bits once enough are held
		emit = cnt_slip >= CNT_W'(pcs_pkg::BLOCK_W);
		shift_next = shift_slip;
		cnt_next = cnt_slip;
		if (emit) begin
			shift_next = shift_slip >> pcs_pkg::BLOCK_W;
			cnt_next = cnt_slip - CNT_W'(pcs_pkg::BLOCK_W);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || !lock_v_i) begin
			shift_q <= '0;
			cnt_q <= '0;
			valid_o <= 1'b0;
		end else begin
			shift_q <= shift_next;
			cnt_q <= cnt_next;
			valid_o <= emit;
		end
	end

	// block payload, header first on the wire
	always_ff @(posedge clk) begin
		if (emit) begin
			head_o <= shift_slip[pcs_pkg::HEAD_W-1:0];
			data_o <= shift_slip[pcs_pkg::BLOCK_W-1:pcs_pkg::HEAD_W];
		end
	end

endmodule

//--- source/pcs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared widths and codes for the 10GBASE-R receive path
// bit 0 of a block is the first bit on the wire, header in the low bits
// only the control block types handled by the lite decoder are listed
// ~~~~~~~~~~~~~~~~~~~~
package pcs_pkg;

	// block layout
	localparam int HEAD_W = 2;
	localparam int DATA_W = 64;
	localparam int BLOCK_W = HEAD_W + DATA_W;
	localparam int KEEP_W = DATA_W / 8;

	// sync header, wire order bit0 then bit1
	// data is 0 then 1, control is 1 then 0
	localparam logic [HEAD_W-1:0] SH_DATA = 2'b10;
	localparam logic [HEAD_W-1:0] SH_CTRL = 2'b01;

	// control block type byte, first payload byte of a control block
	typedef enum logic [7:0] {
		BT_IDLE  = 8'h1e,
		BT_START = 8'h78,
		BT_ORD   = 8'h4b,
		BT_TERM0 = 8'h87,
		BT_TERM1 = 8'h99,
		BT_TERM2 = 8'haa,
		BT_TERM3 = 8'hb4,
		BT_TERM4 = 8'hcc,
		BT_TERM5 = 8'hd2,
		BT_TERM6 = 8'he1,
		BT_TERM7 = 8'hff
	} block_type_e;

	// block lock fsm states
	typedef enum logic [1:0] {
		LOCK_INIT = 2'd0,
		TEST_SH   = 2'd1,
		SLIP      = 2'd2,
		LOCKED    = 2'd3
	} sync_state_e;

endpackage

//--- source/pcs_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// 10GBASE-R receive pcs, single clock, no back-pressure
// gearbox block reaches the mac outputs 2 cycles later if locked
// blocks arriving before lock are dropped
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcs_rx #(
	parameter int SH_CNT_N = 64,
	parameter int SH_BAD_MAX = 16
)(
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        serdes_lock_v_i,
	input  logic [pcs_pkg::DATA_W-1:0]  serdes_data_i,
	output logic                        valid_o,
	output logic                        ctrl_v_o,
	output logic                        idle_v_o,
	output logic                        start_v_o,
	output logic                        term_v_o,
	output logic                        err_v_o,
	output logic                        ord_v_o,
	output logic [pcs_pkg::DATA_W-1:0]  data_o,
	output logic [pcs_pkg::KEEP_W-1:0]  keep_o
);
	// gearbox
	logic                        gb_valid;
	logic [pcs_pkg::HEAD_W-1:0]  gb_head;
	logic [pcs_pkg::DATA_W-1:0]  gb_data;
	logic                        gb_slip;
	// block sync
	logic                        bs_lock;
	// descrambler
	logic                        ds_valid;
	logic [pcs_pkg::HEAD_W-1:0]  ds_head;
	logic [pcs_pkg::DATA_W-1:0]  ds_data;

	gearbox_rx m_gearbox_rx (
		.clk(clk),
		.rst_i(rst_i),
		.lock_v_i(serdes_lock_v_i),
		.data_i(serdes_data_i),
		.slip_i(gb_slip),
		.valid_o(gb_valid),
		.head_o(gb_head),
		.data_o(gb_data)
	);

	// lock hunt runs beside the descrambler on the same blocks
	block_sync_rx #(
		.SH_CNT_N(SH_CNT_N),
		.SH_BAD_MAX(SH_BAD_MAX)
	) m_block_sync_rx (
		.clk(clk),
		.rst_i(rst_i),
		.valid_i(gb_valid),
		.head_i(gb_head),
		.slip_o(gb_slip),
		.lock_o(bs_lock)
	);

	descrambler_rx m_descrambler_rx (
		.clk(clk),
		.rst_i(rst_i),
		.valid_i(gb_valid),
		.head_i(gb_head),
		.scram_i(gb_data),
		.valid_o(ds_valid),
		.head_o(ds_head),
		.data_o(ds_data)
	);

	dec_lite_rx m_dec_lite_rx (
		.clk(clk),
		.rst_i(rst_i),
		.valid_i(ds_valid),
		.lock_i(bs_lock),
		.head_i(ds_head),
		.data_i(ds_data),
		.valid_o(valid_o),
		.ctrl_v_o(ctrl_v_o),
		.idle_v_o(idle_v_o),
		.start_v_o(start_v_o),
		.term_v_o(term_v_o),
		.err_v_o(err_v_o),
		.ord_v_o(ord_v_o),
		.data_o(data_o),
		.keep_o(keep_o)
	);

endmodule

//--- verification/pcs_rx_tb_model.svh
// ~~~~~~~~~~~~~~~~~~~~
// transmit side model, included inside the testbench module body
// serial scrambler 1 + x^39 + x^58, bit 0 goes out first
// expected record is {ctrl idle start term err ord, keep, data}
// ~~~~~~~~~~~~~~~~~~~~

// decoder flag patterns, ctrl down to ord
localparam logic [5:0] F_DATA  = 6'b000000;
localparam logic [5:0] F_IDLE  = 6'b110000;
localparam logic [5:0] F_START = 6'b101000;
localparam logic [5:0] F_TERM  = 6'b100100;
localparam logic [5:0] F_ERR   = 6'b000010;
localparam logic [5:0] F_ORD   = 6'b100001;

logic [31:0] lcg_q = 32'd88;
// any start value, the receiver self synchronises
logic [57:0] scr_q = '1;
// wire bits not yet sent
bit          tx_bits[$];
// unscrambled blocks waiting for the wire
logic [65:0] tx_q[$];
logic [77:0] exp_q[$];
logic [7:0]  term_code [8] = '{
	pcs_pkg::BT_TERM0, pcs_pkg::BT_TERM1, pcs_pkg::BT_TERM2, pcs_pkg::BT_TERM3,
	pcs_pkg::BT_TERM4, pcs_pkg::BT_TERM5, pcs_pkg::BT_TERM6, pcs_pkg::BT_TERM7
};

function automatic logic [31:0] lcg_next();
	lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
	return lcg_q;
endfunction

function automatic logic [63:0] rand64();
	logic [31:0] hi;
	logic [31:0] lo;
	hi = lcg_next();
	lo = lcg_next();
	return {hi, lo};
endfunction

// one bit at a time, s = d ^ s[n-39] ^ s[n-58]
function automatic logic [63:0] scramble(input logic [63:0] plain);
	logic [63:0] scr;
	logic        b;
	for (int i = 0; i < 64; i++) begin
		b = plain[i] ^ scr_q[38] ^ scr_q[57];
		scr_q = {scr_q[56:0], b};
		scr[i] = b;
	end
	return scr;
endfunction

task automatic send_data();
	logic [63:0] payload;
	payload = rand64();
	tx_q.push_back({payload, pcs_pkg::SH_DATA});
	exp_q.push_back({F_DATA, 8'hff, payload});
endtask

// type byte first, decoded payload drops it and gets a zero top byte
task automatic send_ctrl(input logic [7:0] btype, input logic [5:0] flags, input logic [7:0] keep);
	logic [63:0] r;
	logic [55:0] rest;
	r = rand64();
	rest = r[55:0];
	// idle characters are all zero
	if (btype == pcs_pkg::BT_IDLE) begin
		rest = '0;
	end
	tx_q.push_back({rest, btype, pcs_pkg::SH_CTRL});
	exp_q.push_back({flags, keep, 8'h00, rest});
endtask

// header 00 or 11, tracked blocks expect an error decode
task automatic send_bad_head(input logic [1:0] head, input bit track);
	logic [63:0] payload;
	payload = rand64();
	tx_q.push_back({payload, head});
	if (track) begin
		exp_q.push_back({F_ERR, 8'h00, payload});
	end
endtask

// next block onto the wire, idle filler when nothing is queued
task automatic load_block();
	logic [65:0] blk;
	logic [65:0] wire_blk;
	blk = {56'd0, pcs_pkg::BT_IDLE, pcs_pkg::SH_CTRL};
	if (tx_q.size() > 0) begin
		blk = tx_q.pop_front();
	end
	wire_blk = {scramble(blk[65:2]), blk[1:0]};
	for (int i = 0; i < 66; i++) begin
		tx_bits.push_back(wire_blk[i]);
	end
endtask

//--- verification/pcs_rx_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// random blocks from a seeded lcg drive the receive pcs
// idle outputs are checked by pattern and all other blocks in queue order
// probes the block lock inside uut to time the lock phases
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pcs_rx_tb;
	// relock may hunt through all 66 offsets
	localparam int TIMEOUT = 5000;
	localparam int SH_CNT_N = 64;
	localparam int SH_BAD_MAX = 16;

	logic                               clk = 1'b0;
	logic                               rst_i;
	logic                               serdes_lock_v_i;
	logic [pcs_pkg::DATA_W-1:0]         serdes_data_i = '0;
	logic                               valid_o;
	logic                               ctrl_v_o;
	logic                               idle_v_o;
	logic                               start_v_o;
	logic                               term_v_o;
	logic                               err_v_o;
	logic                               ord_v_o;
	logic [pcs_pkg::DATA_W-1:0]         data_o;
	logic [pcs_pkg::KEEP_W-1:0]         keep_o;
	logic                               check_en;
	string                              test_name;

	`include "pcs_rx_tb_model.svh"

	pcs_rx #(
		.SH_CNT_N(SH_CNT_N),
		.SH_BAD_MAX(SH_BAD_MAX)
	) uut (
		.clk(clk),
		.rst_i(rst_i),
		.serdes_lock_v_i(serdes_lock_v_i),
		.serdes_data_i(serdes_data_i),
		.valid_o(valid_o),
		.ctrl_v_o(ctrl_v_o),
		.idle_v_o(idle_v_o),
		.start_v_o(start_v_o),
		.term_v_o(term_v_o),
		.err_v_o(err_v_o),
		.ord_v_o(ord_v_o),
		.data_o(data_o),
		.keep_o(keep_o)
	);

	always #20 clk = ~clk;

	// 64 wire bits per clock
	always @(posedge clk) begin : serialise
		logic [63:0] word;
		while (tx_bits.size() < 64) begin
			load_block();
		end
		for (int i = 0; i < 64; i++) begin
			word[i] = tx_bits.pop_front();
		end
		serdes_data_i <= word;
	end

	task automatic report_error(input string what);
		$display("TEST FAILED");
		$display("%s: %s", test_name, what);
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] expd,
			input logic [63:0] act);
		$display("TEST FAILED");
		$display("Fail %s %s expected %h actual %h", test_name, what, expd, act);
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_output();
		logic [77:0] expd;
		logic [5:0]  flags;
		flags = {ctrl_v_o, idle_v_o, start_v_o, term_v_o, err_v_o, ord_v_o};
		if (idle_v_o) begin
			// fillers and queued idles look alike
			assert (flags == F_IDLE)
				else report_mismatch("idle flags", 64'(F_IDLE), 64'(flags));
			assert (keep_o == 8'h00)
				else report_mismatch("idle keep", 64'd0, 64'(keep_o));
			assert (data_o == '0) else report_mismatch("idle data", 64'd0, data_o);
			if (exp_q.size() > 0) begin
				if (exp_q[0][77:72] == F_IDLE) begin
					expd = exp_q.pop_front();
				end
			end
		end else begin
			assert (exp_q.size() > 0) else report_error("block decoded with nothing expected");
			expd = exp_q.pop_front();
			assert (flags == expd[77:72])
				else report_mismatch("flags", 64'(expd[77:72]), 64'(flags));
			assert (keep_o == expd[71:64])
				else report_mismatch("keep", 64'(expd[71:64]), 64'(keep_o));
			// error blocks carry no defined payload
			assert (expd[73] || data_o == expd[63:0])
				else report_mismatch("data", expd[63:0], data_o);
		end
	endtask

	always @(negedge clk) begin
		if (!rst_i && check_en && valid_o) begin
			check_output();
		end
	end

	// lock needs SH_CNT_N good headers and each block takes a cycle
	task automatic wait_first_valid();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			assert (!valid_o || n >= SH_CNT_N)
				else report_error("valid_o high before a full window of good headers");
			if (valid_o) begin
				break;
			end
		end
		assert (valid_o) else report_error("no block lock within the timeout");
	endtask

	task automatic wait_lock_loss();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (!uut.bs_lock) begin
				break;
			end
		end
		assert (!uut.bs_lock) else report_error("block lock held through the bad header burst");
	endtask

	task automatic wait_drain();
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (tx_q.size() == 0 && exp_q.size() == 0) begin
				break;
			end
		end
		assert (exp_q.size() == 0) else report_error("expected blocks never reached the outputs");
	endtask

	initial begin
		logic [31:0] r;
		int          offset;
		rst_i = 1'b1;
		serdes_lock_v_i = 1'b0;
		check_en = 1'b1;
		test_name = "reset";
		// 1 to 65 junk bits ahead of the first block
		r = lcg_next();
		offset = 1 + int'(r % 32'd65);
		for (int i = 0; i < offset; i++) begin
			r = lcg_next();
			tx_bits.push_back(r[16]);
		end
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		serdes_lock_v_i <= 1'b1;

		test_name = "lock";
		wait_first_valid();

		test_name = "data";
		repeat (40) begin
			send_data();
		end
		wait_drain();

		test_name = "control";
		send_ctrl(pcs_pkg::BT_IDLE, F_IDLE, 8'h00);
		send_ctrl(pcs_pkg::BT_ORD, F_ORD, 8'h00);
		// type 00 is no known block type
		send_ctrl(8'h00, F_ERR | 6'b100000, 8'h00);
		for (int k = 0; k < 8; k++) begin
			send_ctrl(pcs_pkg::BT_START, F_START, 8'h7f);
			send_data();
			// term k keeps its k low bytes
			send_ctrl(term_code[k], F_TERM, 8'((9'd1 << k) - 9'd1));
		end
		wait_drain();

		test_name = "bad header";
		send_data();
		send_bad_head(2'b00, 1'b1);
		send_data();
		send_bad_head(2'b11, 1'b1);
		send_data();
		wait_drain();
		assert (uut.bs_lock) else report_error("block lock lost after two bad headers");

		test_name = "relock";
		check_en <= 1'b0;
		// 48 in a row puts at least 16 into one 64 block window
		repeat (48) begin
			send_bad_head(2'b11, 1'b0);
		end
		wait_lock_loss();
		wait_first_valid();
		check_en <= 1'b1;
		repeat (20) begin
			send_data();
		end
		send_ctrl(pcs_pkg::BT_START, F_START, 8'h7f);
		send_ctrl(term_code[5], F_TERM, 8'h1f);
		wait_drain();

		$display("TEST PASSED");
		$finish;
	end

endmodule
